// File: soc_pkg.sv
// shared bus subsystem definitions
// region decode, register indices and interrupt bit positions
`default_nettype none

package soc_pkg;

	// bus data width
	localparam int WB_DAT_WIDTH = 32;

	// decoded bus target
	typedef enum logic [2:0] {
		REGION_SRAM,
		REGION_IRC,
		REGION_TIMER,
		REGION_GPIO,
		REGION_NONE
	} region_t;

	// map on the top byte of the byte address
	localparam logic [7:0] REGION_BASE_SRAM  = 8'h00;
	localparam logic [7:0] REGION_BASE_IRC   = 8'hF0;
	localparam logic [7:0] REGION_BASE_TIMER = 8'hF1;
	localparam logic [7:0] REGION_BASE_GPIO  = 8'hF2;

	// register word indices per slave
	typedef enum logic [1:0] {TIMER_CTRL, TIMER_COMPARE, TIMER_COUNT} timer_reg_t;
	typedef enum logic [1:0] {GPIO_DIR, GPIO_OUT, GPIO_IN} gpio_reg_t;
	typedef enum logic [1:0] {IRC_ENABLE, IRC_PENDING} irc_reg_t;

	// interrupt vector bit positions
	localparam int IRQ_TIMER = 0;
	localparam int IRQ_GPIO  = 1;
	localparam int IRQ_EXT   = 2;

endpackage

`default_nettype wire

// File: wb_addr_decoder.sv
// address decoder for the single bus level
// turns the top address byte into a region and one slave strobe
`timescale 1ns/10ps
`default_nettype none

module wb_addr_decoder
	import soc_pkg::*;
	(
		input  wire         clk,
		input  wire         reset,

		input  wire  [7:0]  wb_adr_hi_i,
		input  wire         wb_stb_i,

		output logic        sram_stb_o,
		output logic        irc_stb_o,
		output logic        timer_stb_o,
		output logic        gpio_stb_o,
		output logic        unmapped_stb_o,
		output region_t     region_o
	);

	// ----------------------------------------------------------
	//  region lookup
	// ----------------------------------------------------------

	always_comb
	begin
		case (wb_adr_hi_i)
			REGION_BASE_SRAM:  region_o = REGION_SRAM;
			REGION_BASE_IRC:   region_o = REGION_IRC;
			REGION_BASE_TIMER: region_o = REGION_TIMER;
			REGION_BASE_GPIO:  region_o = REGION_GPIO;
			default:           region_o = REGION_NONE;
		endcase
	end

	// strobes qualified by the master strobe
	always_comb
	begin
		sram_stb_o     = wb_stb_i && (region_o == REGION_SRAM);
		irc_stb_o      = wb_stb_i && (region_o == REGION_IRC);
		timer_stb_o    = wb_stb_i && (region_o == REGION_TIMER);
		gpio_stb_o     = wb_stb_i && (region_o == REGION_GPIO);
		unmapped_stb_o = wb_stb_i && (region_o == REGION_NONE);
	end

	// only one target may see an access
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		$onehot0({sram_stb_o, irc_stb_o, timer_stb_o, gpio_stb_o, unmapped_stb_o}));

endmodule

`default_nettype wire

// File: wb_sram.sv
// word SRAM slave
// byte lane writes, registered read data and single-pulse ack
`timescale 1ns/10ps
`default_nettype none

module wb_sram
	import soc_pkg::*;
	#(
		parameter int SRAM_ADR_WIDTH = 8
	)
	(
		input  wire                         clk,
		input  wire                         reset,

		input  wire  [SRAM_ADR_WIDTH-1:0]   adr_i,
		input  wire  [WB_DAT_WIDTH-1:0]     dat_i,
		input  wire                         we_i,
		input  wire  [WB_DAT_WIDTH/8-1:0]   sel_i,
		input  wire                         stb_i,
		output logic [WB_DAT_WIDTH-1:0]     dat_o,
		output logic                        ack_o
	);

	logic [WB_DAT_WIDTH-1:0] mem [2**SRAM_ADR_WIDTH];

	// one ack per access, the master drops stb after it
	always_ff @(posedge clk)
	begin
		if (reset)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i && !ack_o;
	end

	// write lanes and read word on the access edge
	always_ff @(posedge clk)
	begin
		if (stb_i && !ack_o)
		begin
			if (we_i)
			begin
				for (int i = 0; i < WB_DAT_WIDTH/8; i++)
				begin
					if (sel_i[i])
						mem[adr_i][8*i +: 8] <= dat_i[8*i +: 8];
				end
			end
			dat_o <= mem[adr_i];
		end
	end

endmodule

`default_nettype wire

// File: wb_timer.sv
// compare timer slave
// free-running count with wrap at compare and one-cycle irq pulse
`timescale 1ns/10ps
`default_nettype none

module wb_timer
	import soc_pkg::*;
	(
		input  wire                      clk,
		input  wire                      reset,

		input  wire  [1:0]               adr_i,
		input  wire  [WB_DAT_WIDTH-1:0]  dat_i,
		input  wire                      we_i,
		input  wire                      stb_i,
		output logic [WB_DAT_WIDTH-1:0]  dat_o,
		output logic                     ack_o,

		output logic                     irq_o
	);

	logic                     enable;
	logic [WB_DAT_WIDTH-1:0]  compare;
	logic [WB_DAT_WIDTH-1:0]  count;
	logic                     access;
	logic                     hit;

	assign access = stb_i && !ack_o;
	assign hit    = enable && (count == compare);

	// ----------------------------------------------------------
	//  registers and counter
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack_o   <= 1'b0;
			irq_o   <= 1'b0;
			enable  <= 1'b0;
			compare <= '0;
			count   <= '0;
		end
		else
		begin
			ack_o <= access;
			irq_o <= hit;

			// counting first, a bus write to count overrides it
			if (hit)
				count <= '0;
			else if (enable)
				count <= count + 1'b1;

			if (access && we_i)
			begin
				case (timer_reg_t'(adr_i))
					TIMER_CTRL:    enable  <= dat_i[0];
					TIMER_COMPARE: compare <= dat_i;
					TIMER_COUNT:   count   <= dat_i;
					default:       ;
				endcase
			end
		end
	end

	// read mux, captured on the access edge
	always_ff @(posedge clk)
	begin
		if (access)
		begin
			case (timer_reg_t'(adr_i))
				TIMER_CTRL:    dat_o <= WB_DAT_WIDTH'(enable);
				TIMER_COMPARE: dat_o <= compare;
				TIMER_COUNT:   dat_o <= count;
				default:       dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: wb_gpio.sv
// GPIO slave
// direction and output registers, sampled inputs, rising edge event
`timescale 1ns/10ps
`default_nettype none

module wb_gpio
	import soc_pkg::*;
	#(
		parameter int GPIO_WIDTH = 4
	)
	(
		input  wire                      clk,
		input  wire                      reset,

		input  wire  [1:0]               adr_i,
		input  wire  [WB_DAT_WIDTH-1:0]  dat_i,
		input  wire                      we_i,
		input  wire                      stb_i,
		output logic [WB_DAT_WIDTH-1:0]  dat_o,
		output logic                     ack_o,

		input  wire  [GPIO_WIDTH-1:0]    gpio_i,
		output logic [GPIO_WIDTH-1:0]    gpio_o,
		output logic [GPIO_WIDTH-1:0]    gpio_oe_o,
		output logic                     event_o
	);

	logic [GPIO_WIDTH-1:0] in_q;
	logic [GPIO_WIDTH-1:0] in_prev;
	logic                  access;

	assign access = stb_i && !ack_o;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack_o     <= 1'b0;
			gpio_oe_o <= '0;
			gpio_o    <= '0;
			in_q      <= '0;
			in_prev   <= '0;
			event_o   <= 1'b0;
		end
		else
		begin
			ack_o   <= access;
			in_q    <= gpio_i;
			in_prev <= in_q;
			// rising edge on pins set as input
			event_o <= |(in_q & ~in_prev & ~gpio_oe_o);

			if (access && we_i)
			begin
				case (gpio_reg_t'(adr_i))
					GPIO_DIR: gpio_oe_o <= dat_i[GPIO_WIDTH-1:0];
					GPIO_OUT: gpio_o    <= dat_i[GPIO_WIDTH-1:0];
					default:  ;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (access)
		begin
			case (gpio_reg_t'(adr_i))
				GPIO_DIR: dat_o <= WB_DAT_WIDTH'(gpio_oe_o);
				GPIO_OUT: dat_o <= WB_DAT_WIDTH'(gpio_o);
				GPIO_IN:  dat_o <= WB_DAT_WIDTH'(in_q);
				default:  dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: wb_irc.sv
// interrupt controller slave
// enable mask, pending latch with write-one-to-clear, registered irq
`timescale 1ns/10ps
`default_nettype none

module wb_irc
	import soc_pkg::*;
	#(
		parameter int IRQ_NUM = 3
	)
	(
		input  wire                      clk,
		input  wire                      reset,

		input  wire  [1:0]               adr_i,
		input  wire  [WB_DAT_WIDTH-1:0]  dat_i,
		input  wire                      we_i,
		input  wire                      stb_i,
		output logic [WB_DAT_WIDTH-1:0]  dat_o,
		output logic                     ack_o,

		input  wire  [IRQ_NUM-1:0]       irq_src_i,
		output logic                     irq_o
	);

	logic [IRQ_NUM-1:0] enable;
	logic [IRQ_NUM-1:0] pending;
	logic [IRQ_NUM-1:0] clear;
	logic               access;

	assign access = stb_i && !ack_o;

	// ones written to PENDING drop those bits
	always_comb
	begin
		clear = '0;
		if (access && we_i && (irc_reg_t'(adr_i) == IRC_PENDING))
			clear = dat_i[IRQ_NUM-1:0];
	end

	// ----------------------------------------------------------
	//  pending latch and irq output
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack_o   <= 1'b0;
			enable  <= '0;
			pending <= '0;
			irq_o   <= 1'b0;
		end
		else
		begin
			ack_o <= access;
			// disabled sources are masked, a new event wins over a clear
			pending <= (pending & ~clear) | (irq_src_i & enable);
			irq_o   <= |(pending & enable);

			if (access && we_i && (irc_reg_t'(adr_i) == IRC_ENABLE))
				enable <= dat_i[IRQ_NUM-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (access)
		begin
			case (irc_reg_t'(adr_i))
				IRC_ENABLE:  dat_o <= WB_DAT_WIDTH'(enable);
				IRC_PENDING: dat_o <= WB_DAT_WIDTH'(pending);
				default:     dat_o <= '0;
			endcase
		end
	end

	// no stale interrupt out of reset
	a_irq_after_reset: assert property (@(posedge clk) reset |=> !irq_o);

endmodule

`default_nettype wire

// File: wb_resp_mux.sv
// response multiplexer
// routes the addressed slave's data and ack and acks unmapped accesses
`timescale 1ns/10ps
`default_nettype none

module wb_resp_mux
	import soc_pkg::*;
	(
		input  wire                      clk,
		input  wire                      reset,

		input  wire region_t             region_i,
		input  wire                      unmapped_stb_i,

		input  wire  [WB_DAT_WIDTH-1:0]  sram_dat_i,
		input  wire                      sram_ack_i,
		input  wire  [WB_DAT_WIDTH-1:0]  irc_dat_i,
		input  wire                      irc_ack_i,
		input  wire  [WB_DAT_WIDTH-1:0]  timer_dat_i,
		input  wire                      timer_ack_i,
		input  wire  [WB_DAT_WIDTH-1:0]  gpio_dat_i,
		input  wire                      gpio_ack_i,

		output logic [WB_DAT_WIDTH-1:0]  wb_dat_o,
		output logic                     wb_ack_o,
		output logic                     bus_err_o
	);

	logic err_ack;

	// unmapped path acks like a slave
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			err_ack   <= 1'b0;
			bus_err_o <= 1'b0;
		end
		else
		begin
			err_ack <= unmapped_stb_i && !err_ack;
			// sticky fault until reset
			if (err_ack)
				bus_err_o <= 1'b1;
		end
	end

	always_comb
	begin
		case (region_i)
			REGION_SRAM:  {wb_dat_o, wb_ack_o} = {sram_dat_i, sram_ack_i};
			REGION_IRC:   {wb_dat_o, wb_ack_o} = {irc_dat_i, irc_ack_i};
			REGION_TIMER: {wb_dat_o, wb_ack_o} = {timer_dat_i, timer_ack_i};
			REGION_GPIO:  {wb_dat_o, wb_ack_o} = {gpio_dat_i, gpio_ack_i};
			REGION_NONE:  {wb_dat_o, wb_ack_o} = {{WB_DAT_WIDTH{1'b0}}, err_ack};
			default:      {wb_dat_o, wb_ack_o} = '0;
		endcase
	end

	// a target acks only while its own region is still addressed
	a_ack_routed: assert property (@(posedge clk) disable iff (reset)
		(sram_ack_i || irc_ack_i || timer_ack_i || gpio_ack_i || err_ack) |-> wb_ack_o);
	// acks come from the one strobed target only
	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		$onehot0({sram_ack_i, irc_ack_i, timer_ack_i, gpio_ack_i, err_ack}));

endmodule

`default_nettype wire

// File: soc_top.sv
// bus subsystem top level
// decoder, SRAM, IRC, timer, GPIO and response multiplexer
`timescale 1ns/10ps
`default_nettype none

module soc_top
	import soc_pkg::*;
	#(
		parameter int SRAM_ADR_WIDTH = 8,
		parameter int GPIO_WIDTH     = 4,
		parameter int IRQ_NUM        = 3
	)
	(
		input  wire                      clk,
		input  wire                      reset,

		// master port
		input  wire  [31:2]              wb_adr_i,
		input  wire  [WB_DAT_WIDTH-1:0]  wb_dat_i,
		input  wire                      wb_we_i,
		input  wire  [3:0]               wb_sel_i,
		input  wire                      wb_stb_i,
		output wire  [WB_DAT_WIDTH-1:0]  wb_dat_o,
		output wire                      wb_ack_o,

		input  wire  [GPIO_WIDTH-1:0]    gpio_i,
		output wire  [GPIO_WIDTH-1:0]    gpio_o,
		output wire  [GPIO_WIDTH-1:0]    gpio_oe_o,

		input  wire                      irq_ext_i,
		output wire                      irq_o,
		output wire                      bus_err_o
	);

	wire                     sram_stb, irc_stb, timer_stb, gpio_stb, unmapped_stb;
	wire region_t            region;
	wire [WB_DAT_WIDTH-1:0]  sram_dat, irc_dat, timer_dat, gpio_dat;
	wire                     sram_ack, irc_ack, timer_ack, gpio_ack;
	wire                     timer_irq, gpio_event;
	wire [IRQ_NUM-1:0]       irq_src;

	// interrupt vector
	assign irq_src[IRQ_TIMER] = timer_irq;
	assign irq_src[IRQ_GPIO]  = gpio_event;
	assign irq_src[IRQ_EXT]   = irq_ext_i;

	// ----------------------------------------------------------
	//  decode
	// ----------------------------------------------------------

	wb_addr_decoder u_decoder (
		.clk(clk), .reset(reset),
		.wb_adr_hi_i(wb_adr_i[31:24]), .wb_stb_i(wb_stb_i),
		.sram_stb_o(sram_stb), .irc_stb_o(irc_stb), .timer_stb_o(timer_stb),
		.gpio_stb_o(gpio_stb), .unmapped_stb_o(unmapped_stb), .region_o(region)
	);

	// ----------------------------------------------------------
	//  slaves
	// ----------------------------------------------------------

	wb_sram #(.SRAM_ADR_WIDTH(SRAM_ADR_WIDTH)) u_sram (
		.clk(clk), .reset(reset),
		.adr_i(wb_adr_i[SRAM_ADR_WIDTH+1:2]), .dat_i(wb_dat_i), .we_i(wb_we_i),
		.sel_i(wb_sel_i), .stb_i(sram_stb), .dat_o(sram_dat), .ack_o(sram_ack)
	);

	wb_irc #(.IRQ_NUM(IRQ_NUM)) u_irc (
		.clk(clk), .reset(reset),
		.adr_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .we_i(wb_we_i), .stb_i(irc_stb),
		.dat_o(irc_dat), .ack_o(irc_ack), .irq_src_i(irq_src), .irq_o(irq_o)
	);

	wb_timer u_timer (
		.clk(clk), .reset(reset),
		.adr_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .we_i(wb_we_i), .stb_i(timer_stb),
		.dat_o(timer_dat), .ack_o(timer_ack), .irq_o(timer_irq)
	);

	wb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
		.clk(clk), .reset(reset),
		.adr_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .we_i(wb_we_i), .stb_i(gpio_stb),
		.dat_o(gpio_dat), .ack_o(gpio_ack),
		.gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .event_o(gpio_event)
	);

	// response back to the master
	wb_resp_mux u_resp_mux (
		.clk(clk), .reset(reset),
		.region_i(region), .unmapped_stb_i(unmapped_stb),
		.sram_dat_i(sram_dat), .sram_ack_i(sram_ack),
		.irc_dat_i(irc_dat), .irc_ack_i(irc_ack),
		.timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
		.gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .bus_err_o(bus_err_o)
	);

endmodule

`default_nettype wire

// File: tb_checker.sv
// bus response checker for the subsystem testbench
// ack timing against stb, read data and pin compares, error counts
`timescale 1ns/10ps
`default_nettype none

module tb_checker
	import soc_pkg::*;
	#(
		parameter int GPIO_WIDTH = 4
	)
	(
		input  wire                      clk,
		input  wire                      reset,

		input  wire                      wb_stb_i,
		input  wire                      wb_ack_i,
		input  wire  [WB_DAT_WIDTH-1:0]  wb_dat_i,
		input  wire                      irq_i,
		input  wire                      bus_err_i,
		input  wire  [GPIO_WIDTH-1:0]    gpio_out_i,
		input  wire  [GPIO_WIDTH-1:0]    gpio_oe_i,

		// expected values from the driver
		input  wire                      exp_valid_i,
		input  wire  [WB_DAT_WIDTH-1:0]  exp_data_i,
		input  wire                      pin_chk_i,
		input  wire  [31:0]              exp_pins_i,

		output int                       checks_o,
		output int                       errors_o
	);

	int                      checks = 0;
	int                      errors = 0;
	logic                    stb_q;
	logic                    rise_q;
	logic                    reset_q;
	logic [2*GPIO_WIDTH+1:0] pins;

	assign checks_o = checks;
	assign errors_o = errors;
	assign pins     = {bus_err_i, irq_i, gpio_oe_i, gpio_out_i};

	task automatic flag_mismatch(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	// ----------------------------------------------------------
	//  compares on every rising edge
	// ----------------------------------------------------------

	always @(posedge clk)
	begin
		reset_q <= reset;
		if (reset)
		begin
			stb_q  <= 1'b0;
			rise_q <= 1'b0;
		end
		else
		begin
			stb_q  <= wb_stb_i;
			rise_q <= wb_stb_i && !stb_q;

			// first cycle out of reset
			if (reset_q)
			begin
				checks++;
				if (wb_ack_i !== 1'b0 || irq_i !== 1'b0)
					flag_mismatch($sformatf("ack %b irq %b after reset, expected low",
						wb_ack_i, irq_i));
			end

			// ack only in the cycle after stb rose
			if (wb_ack_i !== rise_q)
				flag_mismatch($sformatf("ack %b, expected %b one cycle after stb",
					wb_ack_i, rise_q));
			if (wb_ack_i)
				checks++;

			if (wb_ack_i && exp_valid_i)
			begin
				checks++;
				if (wb_dat_i !== exp_data_i)
					flag_mismatch($sformatf("read data %h, expected %h",
						wb_dat_i, exp_data_i));
			end

			// bus_err, irq, oe and out packed together
			if (pin_chk_i)
			begin
				checks++;
				if (pins !== exp_pins_i[2*GPIO_WIDTH+1:0])
					flag_mismatch($sformatf("pins %h, expected %h",
						pins, exp_pins_i[2*GPIO_WIDTH+1:0]));
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_soc.sv
// testbench top for the bus subsystem
// clock, reset, stimulus table and bus master driver loop
`timescale 1ns/10ps
`default_nettype none

module tb_soc
	import soc_pkg::*;
	();

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_WAIT_IRQ, OP_DRIVE, OP_CHECK} op_t;

	localparam int         TABLE_SIZE    = 64;
	localparam int         TIMEOUT       = 50;
	localparam logic [7:0] UNMAPPED_BASE = 8'h40;

	logic                     clk;
	logic                     reset;
	logic [31:2]              wb_adr;
	logic [WB_DAT_WIDTH-1:0]  wb_dat_w;
	logic                     wb_we;
	logic [3:0]               wb_sel;
	logic                     wb_stb;
	wire  [WB_DAT_WIDTH-1:0]  wb_dat_r;
	wire                      wb_ack;
	logic [3:0]               gpio_in;
	wire  [3:0]               gpio_out;
	wire  [3:0]               gpio_oe;
	logic                     irq_ext;
	wire                      irq;
	wire                      bus_err;

	// expected values for the checker
	logic                     exp_valid;
	logic [31:0]              exp_data;
	logic                     pin_chk;
	logic [31:0]              exp_pins;
	int                       check_count;
	int                       error_count;

	// stimulus table
	op_t                      tab_op  [TABLE_SIZE];
	logic [31:0]              tab_adr [TABLE_SIZE];
	logic [31:0]              tab_dat [TABLE_SIZE];
	logic [3:0]               tab_sel [TABLE_SIZE];
	logic [31:0]              tab_exp [TABLE_SIZE];
	int                       tab_len;
	integer                   seed;
	int                       timeouts;

	soc_top #(.SRAM_ADR_WIDTH(8), .GPIO_WIDTH(4), .IRQ_NUM(3)) uut (
		.clk(clk), .reset(reset),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_we_i(wb_we),
		.wb_sel_i(wb_sel), .wb_stb_i(wb_stb), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
		.gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe),
		.irq_ext_i(irq_ext), .irq_o(irq), .bus_err_o(bus_err)
	);

	tb_checker #(.GPIO_WIDTH(4)) u_checker (
		.clk(clk), .reset(reset),
		.wb_stb_i(wb_stb), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r),
		.irq_i(irq), .bus_err_i(bus_err), .gpio_out_i(gpio_out), .gpio_oe_i(gpio_oe),
		.exp_valid_i(exp_valid), .exp_data_i(exp_data),
		.pin_chk_i(pin_chk), .exp_pins_i(exp_pins),
		.checks_o(check_count), .errors_o(error_count)
	);

	// byte address from map byte and word index
	function automatic logic [31:0] reg_addr(input logic [7:0] base, input int idx);
		return {base, 24'd0} | (32'(idx) << 2);
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int i = 0; i < 4; i++)
		begin
			if (sel[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] pin_state(input logic err, input logic irq_lvl,
		input logic [3:0] oe, input logic [3:0] out);
		return {22'd0, err, irq_lvl, oe, out};
	endfunction

	task automatic add_entry(input op_t op, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input logic [31:0] exp_val);
		tab_op[tab_len]  = op;
		tab_adr[tab_len] = adr;
		tab_dat[tab_len] = dat;
		tab_sel[tab_len] = sel;
		tab_exp[tab_len] = exp_val;
		tab_len++;
	endtask

	// ----------------------------------------------------------
	//  stimulus table
	// ----------------------------------------------------------

	task automatic build_table();
		logic [31:0] words [4];
		logic [31:0] fresh;
		tab_len = 0;
		for (int k = 0; k < 4; k++)
		begin
			words[k] = $random(seed);
			add_entry(OP_WRITE, reg_addr(REGION_BASE_SRAM, 5 + k * 37), words[k], 4'hF, '0);
		end
		for (int k = 0; k < 4; k++)
			add_entry(OP_READ, reg_addr(REGION_BASE_SRAM, 5 + k * 37), '0, 4'hF, words[k]);
		// partial writes touch only the selected lanes
		fresh = $random(seed);
		words[1] = merge_lanes(words[1], fresh, 4'b0101);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_SRAM, 42), fresh, 4'b0101, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_SRAM, 42), '0, 4'hF, words[1]);
		fresh = $random(seed);
		words[2] = merge_lanes(words[2], fresh, 4'b1000);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_SRAM, 79), fresh, 4'b1000, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_SRAM, 79), '0, 4'hF, words[2]);

		// unmapped read, sticky fault after it
		add_entry(OP_CHECK, '0, pin_state(0, 0, 4'h0, 4'h0), 4'h0, '0);
		add_entry(OP_READ, {UNMAPPED_BASE, 24'h000040}, '0, 4'hF, '0);
		add_entry(OP_CHECK, '0, pin_state(1, 0, 4'h0, 4'h0), 4'h0, '0);

		// gpio direction, output and input
		add_entry(OP_WRITE, reg_addr(REGION_BASE_GPIO, GPIO_DIR), 32'h3, 4'hF, '0);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_GPIO, GPIO_OUT), 32'h5, 4'hF, '0);
		add_entry(OP_CHECK, '0, pin_state(1, 0, 4'h3, 4'h5), 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_GPIO, GPIO_DIR), '0, 4'hF, 32'h3);
		add_entry(OP_READ, reg_addr(REGION_BASE_GPIO, GPIO_OUT), '0, 4'hF, 32'h5);
		add_entry(OP_DRIVE, '0, 32'h0A, 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_GPIO, GPIO_IN), '0, 4'hF, 32'hA);

		// timer interrupt through the irc
		add_entry(OP_WRITE, reg_addr(REGION_BASE_IRC, IRC_ENABLE), 1 << IRQ_TIMER, 4'hF, '0);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_TIMER, TIMER_COMPARE), 32'd5, 4'hF, '0);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_TIMER, TIMER_CTRL), 32'd1, 4'hF, '0);
		add_entry(OP_WAIT_IRQ, '0, '0, 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_IRC, IRC_PENDING), '0, 4'hF, 1 << IRQ_TIMER);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_TIMER, TIMER_CTRL), 32'd0, 4'hF, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_TIMER, TIMER_COMPARE), '0, 4'hF, 32'd5);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_IRC, IRC_PENDING), 1 << IRQ_TIMER, 4'hF, '0);
		add_entry(OP_CHECK, '0, pin_state(1, 0, 4'h3, 4'h5), 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_IRC, IRC_PENDING), '0, 4'hF, '0);

		// external level, first masked then enabled
		add_entry(OP_DRIVE, '0, 32'h1A, 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_IRC, IRC_PENDING), '0, 4'hF, '0);
		add_entry(OP_CHECK, '0, pin_state(1, 0, 4'h3, 4'h5), 4'h0, '0);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_IRC, IRC_ENABLE), 1 << IRQ_EXT, 4'hF, '0);
		add_entry(OP_WAIT_IRQ, '0, '0, 4'h0, '0);
		add_entry(OP_READ, reg_addr(REGION_BASE_IRC, IRC_PENDING), '0, 4'hF, 1 << IRQ_EXT);
		add_entry(OP_DRIVE, '0, 32'h0A, 4'h0, '0);
		add_entry(OP_WRITE, reg_addr(REGION_BASE_IRC, IRC_PENDING), 1 << IRQ_EXT, 4'hF, '0);
		add_entry(OP_CHECK, '0, pin_state(1, 0, 4'h3, 4'h5), 4'h0, '0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------
	//  master driver loop
	// ----------------------------------------------------------

	initial
	begin
		int idx;
		int wait_cnt;
		reset     = 1'b1;
		wb_adr    = '0;
		wb_dat_w  = '0;
		wb_we     = 1'b0;
		wb_sel    = 4'h0;
		wb_stb    = 1'b0;
		gpio_in   = 4'h0;
		irq_ext   = 1'b0;
		exp_valid = 1'b0;
		exp_data  = '0;
		pin_chk   = 1'b0;
		exp_pins  = '0;
		seed      = 98;
		timeouts  = 0;
		build_table();
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		for (idx = 0; idx < tab_len && timeouts == 0; idx++)
		begin
			@(posedge clk);
			case (tab_op[idx])
				OP_WRITE, OP_READ:
				begin
					wb_adr    <= tab_adr[idx][31:2];
					wb_dat_w  <= tab_dat[idx];
					wb_we     <= (tab_op[idx] == OP_WRITE);
					wb_sel    <= tab_sel[idx];
					wb_stb    <= 1'b1;
					exp_valid <= (tab_op[idx] == OP_READ);
					exp_data  <= tab_exp[idx];
					wait_cnt = 0;
					do
					begin
						@(posedge clk);
						wait_cnt++;
					end while (!wb_ack && wait_cnt < TIMEOUT);
					wb_stb    <= 1'b0;
					exp_valid <= 1'b0;
					if (!wb_ack)
					begin
						$display("timeout: no ack for entry %0d", idx);
						timeouts++;
					end
				end
				OP_WAIT_IRQ:
				begin
					wait_cnt = 0;
					while (!irq && wait_cnt < TIMEOUT)
					begin
						@(posedge clk);
						wait_cnt++;
					end
					if (!irq)
					begin
						$display("timeout: irq did not rise for entry %0d", idx);
						timeouts++;
					end
				end
				OP_DRIVE:
				begin
					gpio_in <= tab_dat[idx][3:0];
					irq_ext <= tab_dat[idx][4];
				end
				OP_CHECK:
				begin
					pin_chk  <= 1'b1;
					exp_pins <= tab_dat[idx];
					@(posedge clk);
					pin_chk  <= 1'b0;
				end
				default:
					$display("unknown table op at entry %0d", idx);
			endcase
		end

		// let the checker see the last edge, then read counts
		@(posedge clk);
		@(negedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
soc_pkg.sv
wb_addr_decoder.sv
wb_sram.sv
wb_timer.sv
wb_gpio.sv
wb_irc.sv
wb_resp_mux.sv
soc_top.sv
tb_checker.sv
tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_pkg.sv
  - wb_addr_decoder.sv
  - wb_sram.sv
  - wb_timer.sv
  - wb_gpio.sv
  - wb_irc.sv
  - wb_resp_mux.sv
  - soc_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_soc.sv
